/* hw/soc_pkg.sv */
package soc_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////

  parameter int XLEN         = 32;
  parameter int PORT_LEN     = 16;
  parameter int INT_VECT_LEN = 5;

  // default region bounds, end is exclusive
  parameter logic [XLEN-1:0] BOOT_BASE = 32'h0000_0000;
  parameter logic [XLEN-1:0] BOOT_END  = 32'h0000_0400;
  parameter logic [XLEN-1:0] GEN_BASE  = 32'h0000_1000;
  parameter logic [XLEN-1:0] GEN_END   = 32'h0000_1040;
  parameter logic [XLEN-1:0] PROG_BASE = 32'h0001_0000;
  parameter logic [XLEN-1:0] PROG_END  = 32'h0002_0000;
  parameter logic [XLEN-1:0] DATA_BASE = 32'h0002_0000;
  parameter logic [XLEN-1:0] DATA_END  = 32'h0003_0000;

  ////////////////////////////////////////
  // bus types
  ////////////////////////////////////////

  // bit positions inside region_sel_t
  typedef enum logic [1:0] {
    REG_BOOT    = 2'd0,
    REG_GENERAL = 2'd1,
    REG_PROG    = 2'd2,
    REG_DATA    = 2'd3
  } region_e;

  typedef logic [3:0] region_sel_t;

  typedef struct packed {
    logic                read;
    logic                write;
    logic [XLEN-1:0]     addr;
    logic [PORT_LEN-1:0] wdata;
    // bit 1 is the upper byte
    logic [1:0]          be;
  } bus_req_t;

  typedef struct packed {
    logic [PORT_LEN-1:0] rdata;
    logic                illegal;
  } bus_rsp_t;

  // all strobes active low
  typedef struct packed {
    logic [15:0] addr;
    logic [15:0] dout;
    logic        we_n;
    logic        ce_n;
    logic        oe_n;
    logic        ub_n;
    logic        lb_n;
  } sram_pins_t;

  // high byte of uart offset 0
  typedef struct packed {
    logic [5:0] reserved;
    logic       rx_valid;
    logic       tx_busy;
  } uart_status_t;

endpackage

/* hw/mem_region_decode.sv */
`timescale 1ns/10ps

module mem_region_decode #(
  parameter logic [soc_pkg::XLEN-1:0] BOOT_BASE = soc_pkg::BOOT_BASE,
  parameter logic [soc_pkg::XLEN-1:0] BOOT_END  = soc_pkg::BOOT_END,
  parameter logic [soc_pkg::XLEN-1:0] GEN_BASE  = soc_pkg::GEN_BASE,
  parameter logic [soc_pkg::XLEN-1:0] GEN_END   = soc_pkg::GEN_END,
  parameter logic [soc_pkg::XLEN-1:0] PROG_BASE = soc_pkg::PROG_BASE,
  parameter logic [soc_pkg::XLEN-1:0] PROG_END  = soc_pkg::PROG_END,
  parameter logic [soc_pkg::XLEN-1:0] DATA_BASE = soc_pkg::DATA_BASE,
  parameter logic [soc_pkg::XLEN-1:0] DATA_END  = soc_pkg::DATA_END
) (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  soc_pkg::bus_req_t               req_i,
  input  logic [soc_pkg::PORT_LEN-1:0]    boot_rdata_i,
  input  logic [soc_pkg::PORT_LEN-1:0]    sram_rdata_i,
  input  logic [soc_pkg::PORT_LEN-1:0]    gen_rdata_i,
  output soc_pkg::region_sel_t            sel_o,
  output soc_pkg::bus_rsp_t               rsp_o
);

  soc_pkg::region_sel_t sel;
  soc_pkg::region_sel_t rd_sel_q;
  logic                 illegal_q;
  logic                 strobe;

  // half-open bounds, base inclusive
  always_comb begin
    sel = '0;
    sel[soc_pkg::REG_BOOT]    = (req_i.addr >= BOOT_BASE) && (req_i.addr < BOOT_END);
    sel[soc_pkg::REG_GENERAL] = (req_i.addr >= GEN_BASE) && (req_i.addr < GEN_END);
    sel[soc_pkg::REG_PROG]    = (req_i.addr >= PROG_BASE) && (req_i.addr < PROG_END);
    sel[soc_pkg::REG_DATA]    = (req_i.addr >= DATA_BASE) && (req_i.addr < DATA_END);
  end

  assign sel_o  = sel;
  assign strobe = req_i.read | req_i.write;

  // remember which device answers the read
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rd_sel_q  <= '0;
      illegal_q <= 1'b0;
    end else begin
      if (req_i.read) begin
        rd_sel_q <= sel;
      end
      illegal_q <= strobe & ~(|sel);
    end
  end

  always_comb begin
    rsp_o = '0;
    if (rd_sel_q[soc_pkg::REG_BOOT]) begin
      rsp_o.rdata = boot_rdata_i;
    end else if (rd_sel_q[soc_pkg::REG_GENERAL]) begin
      rsp_o.rdata = gen_rdata_i;
    end else if (rd_sel_q[soc_pkg::REG_PROG] || rd_sel_q[soc_pkg::REG_DATA]) begin
      // program and data share the sram
      rsp_o.rdata = sram_rdata_i;
    end
    rsp_o.illegal = illegal_q;
  end

endmodule

/* hw/boot_ram.sv */
`timescale 1ns/10ps

module boot_ram #(
  parameter int WORDS_LOG2 = 9
) (
  input  logic                         clk_i,
  input  logic                         sel_i,
  input  soc_pkg::bus_req_t            req_i,
  output logic [soc_pkg::PORT_LEN-1:0] rdata_o
);

  logic [soc_pkg::PORT_LEN-1:0] mem [2**WORDS_LOG2];
  logic [WORDS_LOG2-1:0]        idx;
  logic [soc_pkg::PORT_LEN-1:0] rdata_q;

  // byte address, bit 0 ignored
  assign idx = req_i.addr[WORDS_LOG2:1];

  always_ff @(posedge clk_i) begin
    if (sel_i && req_i.write) begin
      if (req_i.be[0]) begin
        mem[idx][7:0] <= req_i.wdata[7:0];
      end
      if (req_i.be[1]) begin
        mem[idx][15:8] <= req_i.wdata[15:8];
      end
    end
    // read word held until the next read
    if (sel_i && req_i.read) begin
      rdata_q <= mem[idx];
    end
  end

  assign rdata_o = rdata_q;

endmodule

/* hw/sram16_ctrl.sv */
`timescale 1ns/10ps

module sram16_ctrl (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         sel_i,
  input  soc_pkg::bus_req_t            req_i,
  input  logic [15:0]                  sram_data_i,
  output logic [soc_pkg::PORT_LEN-1:0] rdata_o,
  output soc_pkg::sram_pins_t          sram_o
);

  logic        rd_en;
  logic        wr_en;
  logic        access;
  logic [15:0] rdata_q;

  assign rd_en  = sel_i & req_i.read;
  assign wr_en  = sel_i & req_i.write;
  assign access = rd_en | wr_en;

  ////////////////////////////////////////
  // pin drive
  ////////////////////////////////////////

  // bit 16 inverted so that program memory sits in the lower half
  // and data memory in the upper half
  always_comb begin
    sram_o.addr = {~req_i.addr[16], req_i.addr[15:1]};
    sram_o.dout = req_i.wdata;
    sram_o.ce_n = ~access;
    sram_o.oe_n = ~rd_en;
    sram_o.we_n = ~wr_en;
    // reads always take both lanes
    sram_o.ub_n = ~(access & (rd_en | req_i.be[1]));
    sram_o.lb_n = ~(access & (rd_en | req_i.be[0]));
  end

  ////////////////////////////////////////
  // read capture
  ////////////////////////////////////////

  // sram data settles within the strobe cycle
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rdata_q <= '0;
    end else if (rd_en) begin
      rdata_q <= sram_data_i;
    end
  end

  assign rdata_o = rdata_q;

endmodule

/* hw/uart_core.sv */
`timescale 1ns/10ps

module uart_core #(
  parameter int CLKS_PER_BIT = 4
) (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       tx_start_i,
  input  logic [7:0] tx_data_i,
  input  logic       rx_ack_i,
  input  logic       rx_i,
  output logic       tx_o,
  output logic       tx_busy_o,
  output logic [7:0] rx_data_o,
  output logic       rx_valid_o
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
  localparam int HALF  = CLKS_PER_BIT / 2;

  ////////////////////////////////////////
  // transmitter
  ////////////////////////////////////////

  logic [9:0]       tx_shift_q;
  logic [CNT_W-1:0] tx_clk_cnt_q;
  logic [3:0]       tx_bit_cnt_q;
  logic             tx_busy_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      tx_shift_q   <= '1;
      tx_clk_cnt_q <= '0;
      tx_bit_cnt_q <= '0;
      tx_busy_q    <= 1'b0;
    end else if (!tx_busy_q) begin
      // start request while busy is simply ignored
      if (tx_start_i) begin
        tx_shift_q   <= {1'b1, tx_data_i, 1'b0};
        tx_clk_cnt_q <= '0;
        tx_bit_cnt_q <= '0;
        tx_busy_q    <= 1'b1;
      end
    end else if (tx_clk_cnt_q == CNT_W'(CLKS_PER_BIT - 1)) begin
      tx_clk_cnt_q <= '0;
      tx_shift_q   <= {1'b1, tx_shift_q[9:1]};
      if (tx_bit_cnt_q == 4'd9) begin
        tx_busy_q <= 1'b0;
      end else begin
        tx_bit_cnt_q <= tx_bit_cnt_q + 4'd1;
      end
    end else begin
      tx_clk_cnt_q <= tx_clk_cnt_q + 1'b1;
    end
  end

  assign tx_o      = tx_shift_q[0];
  assign tx_busy_o = tx_busy_q;

  ////////////////////////////////////////
  // receiver
  ////////////////////////////////////////

  logic [1:0]       rx_sync_q;
  logic             rx_s;
  logic             rx_active_q;
  logic [CNT_W-1:0] rx_clk_cnt_q;
  logic [3:0]       rx_bit_cnt_q;
  logic [7:0]       rx_shift_q;
  logic [7:0]       rx_data_q;
  logic             rx_valid_q;
  logic [CNT_W-1:0] rx_tgt;

  assign rx_s = rx_sync_q[1];

  // first wait lands in the middle of the start bit
  assign rx_tgt = (rx_bit_cnt_q == 4'd0) ? CNT_W'(HALF) : CNT_W'(CLKS_PER_BIT - 1);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rx_sync_q    <= 2'b11;
      rx_active_q  <= 1'b0;
      rx_clk_cnt_q <= '0;
      rx_bit_cnt_q <= '0;
      rx_valid_q   <= 1'b0;
    end else begin
      rx_sync_q <= {rx_sync_q[0], rx_i};
      if (rx_ack_i) begin
        rx_valid_q <= 1'b0;
      end
      if (!rx_active_q) begin
        if (!rx_s) begin
          rx_active_q  <= 1'b1;
          rx_clk_cnt_q <= '0;
          rx_bit_cnt_q <= '0;
        end
      end else if (rx_clk_cnt_q == rx_tgt) begin
        rx_clk_cnt_q <= '0;
        rx_bit_cnt_q <= rx_bit_cnt_q + 4'd1;
        if (rx_bit_cnt_q == 4'd0) begin
          // glitch, not a real start bit
          if (rx_s) begin
            rx_active_q <= 1'b0;
          end
        end else if (rx_bit_cnt_q == 4'd9) begin
          rx_active_q <= 1'b0;
          // one byte buffer, newer byte lost while full
          if (rx_s && !rx_valid_q) begin
            rx_data_q  <= rx_shift_q;
            rx_valid_q <= 1'b1;
          end
        end else begin
          rx_shift_q <= {rx_s, rx_shift_q[7:1]};
        end
      end else begin
        rx_clk_cnt_q <= rx_clk_cnt_q + 1'b1;
      end
    end
  end

  assign rx_data_o  = rx_data_q;
  assign rx_valid_o = rx_valid_q;

endmodule

/* hw/general_regs.sv */
`timescale 1ns/10ps

module general_regs #(
  parameter int CLKS_PER_BIT = 4
) (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  logic                             sel_i,
  input  soc_pkg::bus_req_t                req_i,
  input  logic [soc_pkg::INT_VECT_LEN-1:0] irq_src_i,
  input  logic                             uart_rx_i,
  output logic [soc_pkg::PORT_LEN-1:0]     rdata_o,
  output logic                             irq_o,
  output logic                             uart_tx_o
);

  logic [5:0]                       offset;
  logic                             uart_hit;
  logic                             mask_hit;
  logic                             pend_hit;
  logic                             rd_en;
  logic                             wr_en;
  logic                             tx_start;
  logic                             tx_busy;
  logic [7:0]                       rx_data;
  logic                             rx_valid;
  logic                             rx_ack;
  logic [soc_pkg::INT_VECT_LEN-1:0] mask_q;
  logic [soc_pkg::INT_VECT_LEN-1:0] pend_q;
  logic [soc_pkg::INT_VECT_LEN-1:0] pend_clr;
  logic [soc_pkg::PORT_LEN-1:0]     rdata_q;
  soc_pkg::uart_status_t            status;

  ////////////////////////////////////////
  // window decode
  ////////////////////////////////////////

  assign offset   = req_i.addr[5:0];
  // uart data and status share the halfword at offsets 0 and 1
  assign uart_hit = (offset[5:1] == 5'd0);
  assign mask_hit = (offset == 6'd8);
  assign pend_hit = (offset == 6'd10);
  assign rd_en    = sel_i & req_i.read;
  assign wr_en    = sel_i & req_i.write;

  assign tx_start = wr_en & uart_hit & req_i.be[0];
  assign rx_ack   = rd_en & uart_hit;
  assign pend_clr = (wr_en && pend_hit) ? req_i.wdata[soc_pkg::INT_VECT_LEN-1:0] : '0;

  always_comb begin
    status          = '0;
    status.rx_valid = rx_valid;
    status.tx_busy  = tx_busy;
  end

  uart_core #(
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) uart_core_i (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .tx_start_i(tx_start),
    .tx_data_i (req_i.wdata[7:0]),
    .rx_ack_i  (rx_ack),
    .rx_i      (uart_rx_i),
    .tx_o      (uart_tx_o),
    .tx_busy_o (tx_busy),
    .rx_data_o (rx_data),
    .rx_valid_o(rx_valid)
  );

  // interrupt state, clear wins over a new set
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      mask_q <= '0;
      pend_q <= '0;
    end else begin
      if (wr_en && mask_hit) begin
        mask_q <= req_i.wdata[soc_pkg::INT_VECT_LEN-1:0];
      end
      pend_q <= (pend_q | irq_src_i) & ~pend_clr;
    end
  end

  assign irq_o = |(pend_q & mask_q);

  // read word sampled at the strobe, before the ack takes effect
  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      if (uart_hit) begin
        rdata_q <= {status, rx_data};
      end else if (mask_hit) begin
        rdata_q <= {{(soc_pkg::PORT_LEN - soc_pkg::INT_VECT_LEN){1'b0}}, mask_q};
      end else if (pend_hit) begin
        rdata_q <= {{(soc_pkg::PORT_LEN - soc_pkg::INT_VECT_LEN){1'b0}}, pend_q};
      end else begin
        rdata_q <= '0;
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

/* hw/mem_subsys_top.sv */
`timescale 1ns/10ps

module mem_subsys_top #(
  parameter logic [soc_pkg::XLEN-1:0] BOOT_BASE       = soc_pkg::BOOT_BASE,
  parameter logic [soc_pkg::XLEN-1:0] BOOT_END        = soc_pkg::BOOT_END,
  parameter logic [soc_pkg::XLEN-1:0] GEN_BASE        = soc_pkg::GEN_BASE,
  parameter logic [soc_pkg::XLEN-1:0] GEN_END         = soc_pkg::GEN_END,
  parameter logic [soc_pkg::XLEN-1:0] PROG_BASE       = soc_pkg::PROG_BASE,
  parameter logic [soc_pkg::XLEN-1:0] PROG_END        = soc_pkg::PROG_END,
  parameter logic [soc_pkg::XLEN-1:0] DATA_BASE       = soc_pkg::DATA_BASE,
  parameter logic [soc_pkg::XLEN-1:0] DATA_END        = soc_pkg::DATA_END,
  parameter int                       BOOT_WORDS_LOG2 = 9,
  parameter int                       CLKS_PER_BIT    = 4
) (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  soc_pkg::bus_req_t                req_i,
  input  logic [soc_pkg::INT_VECT_LEN-1:0] irq_src_i,
  input  logic                             uart_rx_i,
  input  logic [15:0]                      sram_data_i,
  output soc_pkg::bus_rsp_t                rsp_o,
  output logic                             irq_o,
  output logic                             uart_tx_o,
  output soc_pkg::sram_pins_t              sram_o
);

  soc_pkg::region_sel_t         sel;
  logic [soc_pkg::PORT_LEN-1:0] boot_rdata;
  logic [soc_pkg::PORT_LEN-1:0] sram_rdata;
  logic [soc_pkg::PORT_LEN-1:0] gen_rdata;

  mem_region_decode #(
    .BOOT_BASE(BOOT_BASE),
    .BOOT_END (BOOT_END),
    .GEN_BASE (GEN_BASE),
    .GEN_END  (GEN_END),
    .PROG_BASE(PROG_BASE),
    .PROG_END (PROG_END),
    .DATA_BASE(DATA_BASE),
    .DATA_END (DATA_END)
  ) mem_region_decode_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_i       (req_i),
    .boot_rdata_i(boot_rdata),
    .sram_rdata_i(sram_rdata),
    .gen_rdata_i (gen_rdata),
    .sel_o       (sel),
    .rsp_o       (rsp_o)
  );

  boot_ram #(
    .WORDS_LOG2(BOOT_WORDS_LOG2)
  ) boot_ram_i (
    .clk_i  (clk_i),
    .sel_i  (sel[soc_pkg::REG_BOOT]),
    .req_i  (req_i),
    .rdata_o(boot_rdata)
  );

  // program and data regions both land in the external sram
  sram16_ctrl sram16_ctrl_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .sel_i      (sel[soc_pkg::REG_PROG] | sel[soc_pkg::REG_DATA]),
    .req_i      (req_i),
    .sram_data_i(sram_data_i),
    .rdata_o    (sram_rdata),
    .sram_o     (sram_o)
  );

  general_regs #(
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) general_regs_i (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .sel_i    (sel[soc_pkg::REG_GENERAL]),
    .req_i    (req_i),
    .irq_src_i(irq_src_i),
    .uart_rx_i(uart_rx_i),
    .rdata_o  (gen_rdata),
    .irq_o    (irq_o),
    .uart_tx_o(uart_tx_o)
  );

endmodule

/* tb/sram_model.sv */
`timescale 1ns/10ps

module sram_model (
  input  soc_pkg::sram_pins_t pins_i,
  output logic [15:0]         data_o
);

  logic [15:0] mem [65536];

  // power-up contents vary with every address bit
  initial begin
    for (int i = 0; i < 65536; i++) begin
      mem[i] = 16'(i) ^ 16'hc35a;
    end
  end

  ////////////////////////////////////////
  // asynchronous write, per byte lane
  ////////////////////////////////////////

  // level sensitive while ce_n and we_n are low
  always @(pins_i) begin
    if (!pins_i.ce_n && !pins_i.we_n) begin
      if (!pins_i.ub_n) begin
        mem[pins_i.addr][15:8] = pins_i.dout[15:8];
      end
      if (!pins_i.lb_n) begin
        mem[pins_i.addr][7:0] = pins_i.dout[7:0];
      end
    end
  end

  // bus floats unless the output enable is on
  assign data_o = (!pins_i.ce_n && !pins_i.oe_n) ? mem[pins_i.addr] : 16'hzzzz;

endmodule

/* tb/mem_subsys_tb.sv */
`timescale 1ns/10ps

module mem_subsys_tb;

  localparam int          CLKS_PER_BIT = 4;
  localparam int          RESET_CYCLES = 10;
  localparam logic [31:0] BOOT_BASE    = 32'h0000_0000;
  localparam logic [31:0] BOOT_END     = 32'h0000_0400;
  localparam logic [31:0] GEN_BASE     = 32'h0000_1000;
  localparam logic [31:0] GEN_END      = 32'h0000_1040;
  localparam logic [31:0] PROG_BASE    = 32'h0001_0000;
  localparam logic [31:0] PROG_END     = 32'h0002_0000;
  localparam logic [31:0] DATA_BASE    = 32'h0002_0000;
  localparam logic [31:0] DATA_END     = 32'h0003_0000;
  localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003;

  typedef enum logic [1:0] {
    OP_WRITE,
    OP_READ,
    OP_WAIT_RX
  } op_e;

  typedef struct packed {
    op_e         op;
    logic [31:0] addr;
    logic [15:0] wdata;
    logic [1:0]  be;
    logic [4:0]  src;
    logic [15:0] exp_rdata;
    logic        exp_illegal;
    logic        exp_irq;
  } entry_t;

  logic                clk = 1'b0;
  logic                rst_n;
  soc_pkg::bus_req_t   req;
  soc_pkg::bus_rsp_t   rsp;
  logic [4:0]          irq_src;
  logic                irq;
  logic                uart_tx;
  soc_pkg::sram_pins_t sram_pins;
  logic [15:0]         sram_data;

  // stimulus table and shadow state used to build it
  entry_t      stim_q[$];
  logic [15:0] mem_sh [int];
  logic [4:0]  mask_sh     = '0;
  logic [4:0]  pend_sh     = '0;
  logic [15:0] last_rd_sh  = '0;
  logic        tx_busy_sh  = 1'b0;
  logic [7:0]  tx_byte_sh;
  logic [7:0]  rx_byte_sh;
  logic [31:0] lfsr_q      = 32'h87ba;
  int          n_uart      = 0;
  int          cycle_cnt   = 0;
  int          cycle_limit = 32'h7fff_ffff;
  int          fail_count  = 0;

  always #5 clk = ~clk;

  mem_subsys_top #(
    .BOOT_BASE      (BOOT_BASE),
    .BOOT_END       (BOOT_END),
    .GEN_BASE       (GEN_BASE),
    .GEN_END        (GEN_END),
    .PROG_BASE      (PROG_BASE),
    .PROG_END       (PROG_END),
    .DATA_BASE      (DATA_BASE),
    .DATA_END       (DATA_END),
    .BOOT_WORDS_LOG2(9),
    .CLKS_PER_BIT   (CLKS_PER_BIT)
  ) mem_subsys_top_i (
    .clk_i      (clk),
    .rst_n_i    (rst_n),
    .req_i      (req),
    .irq_src_i  (irq_src),
    .uart_rx_i  (uart_tx),
    .sram_data_i(sram_data),
    .rsp_o      (rsp),
    .irq_o      (irq),
    .uart_tx_o  (uart_tx),
    .sram_o     (sram_pins)
  );

  sram_model sram_model_i (
    .pins_i(sram_pins),
    .data_o(sram_data)
  );

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  // galois lfsr, one step per bit taken
  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v      = {v[14:0], lfsr_q[0]};
      lfsr_q = (lfsr_q >> 1) ^ (lfsr_q[0] ? LFSR_TAPS : 32'h0);
    end
    return v;
  endfunction

  function automatic logic in_range(input logic [31:0] a, input logic [31:0] lo,
                                    input logic [31:0] hi);
    return (a >= lo) && (a < hi);
  endfunction

  function automatic int mem_key(input logic [31:0] a);
    if (in_range(a, BOOT_BASE, BOOT_END)) begin
      return int'(a[9:1]);
    end
    // sram halfword, bit 16 inverted
    return 32'h1_0000 + int'({~a[16], a[15:1]});
  endfunction

  task automatic add_entry(input op_e op, input logic [31:0] addr, input logic [15:0] wdata,
                           input logic [1:0] be, input logic [4:0] src);
    entry_t      e;
    logic        is_mem;
    logic        is_gen;
    logic [5:0]  offs;
    logic [4:0]  clr;
    logic [15:0] old;
    int          key;
    is_mem = in_range(addr, BOOT_BASE, BOOT_END) || in_range(addr, PROG_BASE, PROG_END) ||
             in_range(addr, DATA_BASE, DATA_END);
    is_gen = in_range(addr, GEN_BASE, GEN_END);
    offs   = addr[5:0];
    key    = mem_key(addr);
    clr    = '0;
    if (op == OP_WAIT_RX) begin
      n_uart++;
      rx_byte_sh = tx_byte_sh;
      tx_busy_sh = 1'b0;
      last_rd_sh = {8'h02, rx_byte_sh};
    end else if (op == OP_READ) begin
      if (is_mem) begin
        last_rd_sh = mem_sh[key];
      end else if (is_gen && offs[5:1] == 5'd0) begin
        last_rd_sh = {6'd0, 1'b0, tx_busy_sh, rx_byte_sh};
      end else if (is_gen && offs == 6'd8) begin
        last_rd_sh = {11'd0, mask_sh};
      end else if (is_gen && offs == 6'd10) begin
        last_rd_sh = {11'd0, pend_sh};
      end else begin
        last_rd_sh = '0;
      end
    end else if (is_mem) begin
      old = mem_sh.exists(key) ? mem_sh[key] : 16'hxxxx;
      if (be[0]) begin
        old[7:0] = wdata[7:0];
      end
      if (be[1]) begin
        old[15:8] = wdata[15:8];
      end
      mem_sh[key] = old;
    end else if (is_gen && offs[5:1] == 5'd0 && be[0]) begin
      // a second write while sending is lost
      if (!tx_busy_sh) begin
        tx_busy_sh = 1'b1;
        tx_byte_sh = wdata[7:0];
      end
    end else if (is_gen && offs == 6'd8) begin
      mask_sh = wdata[4:0];
    end else if (is_gen && offs == 6'd10) begin
      clr = wdata[4:0];
    end
    pend_sh       = (pend_sh | src) & ~clr;
    e.op          = op;
    e.addr        = addr;
    e.wdata       = wdata;
    e.be          = be;
    e.src         = src;
    e.exp_rdata   = last_rd_sh;
    e.exp_illegal = ~(is_mem | is_gen);
    e.exp_irq     = |(pend_sh & mask_sh);
    // source is still high at the idle edge
    pend_sh = pend_sh | src;
    stim_q.push_back(e);
  endtask

  task automatic build_table();
    // interrupt registers after reset
    add_entry(OP_READ,    GEN_BASE + 32'd10, '0, 2'b11, '0);
    add_entry(OP_READ,    GEN_BASE + 32'd8,  '0, 2'b11, '0);
    // boot ram, full words then single lanes
    add_entry(OP_WRITE,   32'h0000_0010, rand_bits(16), 2'b11, '0);
    add_entry(OP_WRITE,   32'h0000_03fe, rand_bits(16), 2'b11, '0);
    add_entry(OP_READ,    32'h0000_0010, '0, 2'b11, '0);
    add_entry(OP_WRITE,   32'h0000_0010, rand_bits(16), 2'b01, '0);
    add_entry(OP_READ,    32'h0000_0010, '0, 2'b11, '0);
    add_entry(OP_WRITE,   32'h0000_0011, rand_bits(16), 2'b10, '0);
    add_entry(OP_READ,    32'h0000_0010, '0, 2'b11, '0);
    add_entry(OP_READ,    32'h0000_03fe, '0, 2'b11, '0);
    // program and data at equal offsets stay apart
    add_entry(OP_WRITE,   32'h0001_0020, rand_bits(16), 2'b11, '0);
    add_entry(OP_WRITE,   32'h0002_0020, rand_bits(16), 2'b11, '0);
    add_entry(OP_READ,    32'h0001_0020, '0, 2'b11, '0);
    add_entry(OP_READ,    32'h0002_0020, '0, 2'b11, '0);
    add_entry(OP_WRITE,   32'h0002_0020, rand_bits(16), 2'b10, '0);
    add_entry(OP_WRITE,   32'h0001_0020, rand_bits(16), 2'b01, '0);
    add_entry(OP_READ,    32'h0002_0020, '0, 2'b11, '0);
    add_entry(OP_READ,    32'h0001_0020, '0, 2'b11, '0);
    add_entry(OP_WRITE,   32'h0001_fffe, rand_bits(16), 2'b11, '0);
    add_entry(OP_WRITE,   32'h0002_0000, rand_bits(16), 2'b11, '0);
    add_entry(OP_WRITE,   32'h0002_fffe, rand_bits(16), 2'b11, '0);
    add_entry(OP_READ,    32'h0001_fffe, '0, 2'b11, '0);
    add_entry(OP_READ,    32'h0002_0000, '0, 2'b11, '0);
    add_entry(OP_READ,    32'h0002_fffe, '0, 2'b11, '0);
    // outside every region
    add_entry(OP_READ,    32'h0000_0400, '0, 2'b11, '0);
    add_entry(OP_WRITE,   32'h0000_0800, 16'h1234, 2'b11, '0);
    add_entry(OP_READ,    32'h0000_1040, '0, 2'b11, '0);
    add_entry(OP_READ,    32'h0003_0000, '0, 2'b11, '0);
    add_entry(OP_WRITE,   32'hffff_fffe, 16'hbeef, 2'b11, '0);
    // unused window offsets
    add_entry(OP_READ,    GEN_BASE + 32'd4,  '0, 2'b11, '0);
    add_entry(OP_READ,    GEN_BASE + 32'd62, '0, 2'b11, '0);
    // uart loopback, then busy status and a dropped write
    add_entry(OP_WRITE,   GEN_BASE, rand_bits(8), 2'b01, '0);
    add_entry(OP_WAIT_RX, GEN_BASE, '0, 2'b11, '0);
    add_entry(OP_READ,    GEN_BASE, '0, 2'b11, '0);
    add_entry(OP_WRITE,   GEN_BASE, rand_bits(8), 2'b01, '0);
    add_entry(OP_READ,    GEN_BASE, '0, 2'b11, '0);
    add_entry(OP_WRITE,   GEN_BASE, 16'h00ff, 2'b01, '0);
    add_entry(OP_WAIT_RX, GEN_BASE, '0, 2'b11, '0);
    add_entry(OP_READ,    GEN_BASE, '0, 2'b11, '0);
    // interrupt pending, mask and clear
    add_entry(OP_WRITE,   GEN_BASE + 32'd8,  16'h0005, 2'b11, 5'b00000);
    add_entry(OP_READ,    GEN_BASE + 32'd10, '0, 2'b11, 5'b00100);
    add_entry(OP_READ,    GEN_BASE + 32'd10, '0, 2'b11, 5'b00010);
    add_entry(OP_WRITE,   GEN_BASE + 32'd10, 16'h0004, 2'b11, 5'b00000);
    add_entry(OP_READ,    GEN_BASE + 32'd10, '0, 2'b11, 5'b00000);
    add_entry(OP_WRITE,   GEN_BASE + 32'd8,  16'h0002, 2'b11, 5'b00000);
    add_entry(OP_WRITE,   GEN_BASE + 32'd10, 16'h0002, 2'b11, 5'b00000);
    add_entry(OP_READ,    GEN_BASE + 32'd10, '0, 2'b11, 5'b00000);
  endtask

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  task automatic report_failure(input string msg);
    fail_count++;
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_rsp(input string where, input soc_pkg::bus_rsp_t got,
                           input soc_pkg::bus_rsp_t exp);
    if (got !== exp) begin
      report_failure($sformatf("FAILED at %0t: rsp_o (%s) got rdata=%h illegal=%b, %s%h %s%b",
                               $time, where, got.rdata, got.illegal,
                               "expected rdata=", exp.rdata, "illegal=", exp.illegal));
    end
  endtask

  task automatic check_irq(input string where, input logic got, input logic exp);
    if (got !== exp) begin
      report_failure($sformatf("FAILED at %0t: irq_o (%s) got %b expected %b",
                               $time, where, got, exp));
    end
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      report_failure($sformatf("FAILED at %0t: %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_sram_pins(input string where, input soc_pkg::sram_pins_t got,
                                 input soc_pkg::sram_pins_t exp);
    if (got !== exp) begin
      report_failure($sformatf("FAILED at %0t: sram_o (%s) got %h expected %h",
                               $time, where, got, exp));
    end
  endtask

  ////////////////////////////////////////
  // bus master
  ////////////////////////////////////////

  // one strobe cycle, one idle cycle, sample at the falling edge
  task automatic bus_access(input logic rd, input logic wr, input logic [31:0] addr,
                            input logic [15:0] wdata, input logic [1:0] be,
                            input logic [4:0] src);
    @(posedge clk);
    #1;
    req.read  = rd;
    req.write = wr;
    req.addr  = addr;
    req.wdata = wdata;
    req.be    = be;
    irq_src   = src;
    @(posedge clk);
    #1;
    req = '0;
    @(negedge clk);
  endtask

  task automatic run_entry(input int idx, input entry_t e, input soc_pkg::sram_pins_t idle);
    soc_pkg::bus_rsp_t     exp;
    soc_pkg::uart_status_t st;
    string                 where;
    exp.rdata   = e.exp_rdata;
    exp.illegal = e.exp_illegal;
    where       = $sformatf("entry %0d", idx);
    if (e.op == OP_WAIT_RX) begin
      // poll status until the looped-back byte is in
      do begin
        bus_access(1'b1, 1'b0, e.addr, '0, 2'b11, e.src);
        st = rsp.rdata[15:8];
      end while (!st.rx_valid);
    end else begin
      bus_access(e.op == OP_READ, e.op == OP_WRITE, e.addr, e.wdata, e.be, e.src);
    end
    check_rsp(where, rsp, exp);
    check_irq(where, irq, e.exp_irq);
    check_sram_pins(where, sram_pins, idle);
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      report_failure($sformatf("timeout: run did not finish within %0d clock cycles",
                               cycle_limit));
    end
  end

  initial begin
    soc_pkg::sram_pins_t idle_pins;
    rst_n   = 1'b0;
    req     = '0;
    irq_src = '0;
    build_table();
    cycle_limit = RESET_CYCLES + 2 * stim_q.size() + 12 * CLKS_PER_BIT * n_uart + 16;
    // idle request at address 0 maps to sram halfword 16'h8000
    idle_pins      = '1;
    idle_pins.addr = 16'h8000;
    idle_pins.dout = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    check_sram_pins("after reset", sram_pins, idle_pins);
    check_irq("after reset", irq, 1'b0);
    check_level("uart_tx_o", uart_tx, 1'b1);
    for (int i = 0; i < stim_q.size(); i++) begin
      run_entry(i, stim_q[i], idle_pins);
    end
    if (fail_count == 0) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      $display("TESTBENCH FAILED");
      $fatal(1, "checks failed");
    end
  end

endmodule

/* mem_subsys.f */
hw/soc_pkg.sv
hw/mem_region_decode.sv
hw/boot_ram.sv
hw/sram16_ctrl.sv
hw/uart_core.sv
hw/general_regs.sv
hw/mem_subsys_top.sv
tb/sram_model.sv
tb/mem_subsys_tb.sv

/* Bender.yml */
package:
  name: mem_subsys

sources:
  - files:
      - hw/soc_pkg.sv
      - hw/mem_region_decode.sv
      - hw/boot_ram.sv
      - hw/sram16_ctrl.sv
      - hw/uart_core.sv
      - hw/general_regs.sv
      - hw/mem_subsys_top.sv
  - target: test
    files:
      - tb/sram_model.sv
      - tb/mem_subsys_tb.sv
